// File: pix_pkg.sv
package pix_pkg;

    // ====================
    // Pixel and word widths
    // ====================
    // Raw sensor pixel
    localparam int PIX_BITS = 12;
    // Stored word, pixel zero-extended
    localparam int WORD_BITS = 16;

    // ====================
    // Frame store geometry
    // ====================
    localparam int BLOCK_COUNT = 8;
    localparam int BLOCK_BITS = 3;
    // One block holds exactly one frame
    localparam int FRAME_WORDS = 24;
    localparam int ADDR_BITS = 5;

    // Pixel buffer between gate and store
    localparam int FIFO_DEPTH = 8;

    // Command codes on cmd_op
    localparam logic CMD_CAPTURE = 1'b0;
    localparam logic CMD_READOUT = 1'b1;

endpackage

// File: store_if.sv
`timescale 1ns/10ps

interface store_if;
    import pix_pkg::*;

    // Command handshake
    logic                  cmd_ready;
    logic                  cmd_trigger;
    logic [BLOCK_BITS-1:0] cmd_block;
    logic                  cmd_write;

    // Data handshake, one word per ready/trigger cycle
    logic                  data_ready;
    logic                  data_trigger;
    logic [WORD_BITS-1:0]  data_write;
    logic [WORD_BITS-1:0]  data_read;

    modport ctrl (
        input  cmd_ready, data_ready, data_read,
        output cmd_trigger, cmd_block, cmd_write, data_trigger, data_write
    );

    modport store (
        output cmd_ready, data_ready, data_read,
        input  cmd_trigger, cmd_block, cmd_write, data_trigger, data_write
    );

endinterface

// File: frame_gate.sv
`timescale 1ns/10ps

module frame_gate (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          arm,
    input  logic                          pix_valid,
    input  logic [pix_pkg::PIX_BITS-1:0]  pix_d,
    input  logic                          pix_fv,
    input  logic                          pix_lv,
    output logic                          push,
    output logic [pix_pkg::WORD_BITS-1:0] push_data
);
    import pix_pkg::*;

    localparam logic [1:0] GATE_IDLE       = 2'd0;
    localparam logic [1:0] GATE_WAIT_INV   = 2'd1;
    localparam logic [1:0] GATE_WAIT_START = 2'd2;
    localparam logic [1:0] GATE_IN_FRAME   = 2'd3;

    logic [1:0]          state;
    logic                valid_q;
    logic                fv_q;
    logic                lv_q;
    logic [PIX_BITS-1:0] pix_q;

    // Input register stage for the pixel bus
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            fv_q    <= 1'b0;
            lv_q    <= 1'b0;
        end else begin
            valid_q <= pix_valid;
            fv_q    <= pix_fv;
            lv_q    <= pix_lv;
        end
    end

    always_ff @(posedge clk) begin
        pix_q <= pix_d;
    end

    // ====================
    // Frame tracking
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= GATE_IDLE;
        end else if (arm) begin
            state <= GATE_WAIT_INV;
        end else begin
            case (state)
                // Skip any frame already in progress
                GATE_WAIT_INV:   if (!fv_q) state <= GATE_WAIT_START;
                GATE_WAIT_START: if (fv_q) state <= GATE_IN_FRAME;
                GATE_IN_FRAME:   if (!fv_q) state <= GATE_IDLE;
                default:         state <= GATE_IDLE;
            endcase
        end
    end

    // First pixel may arrive together with the frame-valid edge
    assign push = fv_q && lv_q && valid_q &&
                  (state == GATE_WAIT_START || state == GATE_IN_FRAME);
    assign push_data = {{(WORD_BITS - PIX_BITS){1'b0}}, pix_q};

endmodule

// File: pix_fifo.sv
`timescale 1ns/10ps

module pix_fifo (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          flush,
    input  logic                          push,
    input  logic [pix_pkg::WORD_BITS-1:0] push_data,
    output logic                          not_empty,
    input  logic                          pop,
    output logic [pix_pkg::WORD_BITS-1:0] head
);
    import pix_pkg::*;

    logic [WORD_BITS-1:0]             mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0]    wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0]    rd_ptr;
    logic [$clog2(FIFO_DEPTH+1)-1:0]  count;
    logic                             full;
    logic                             wr_en;
    logic                             rd_en;

    assign full      = (count == ($clog2(FIFO_DEPTH+1))'(FIFO_DEPTH));
    assign not_empty = (count != '0);
    // Overflow drops the incoming word
    assign wr_en     = push && !full;
    assign rd_en     = pop && not_empty;

    // ====================
    // Pointers and fill level
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_ptr] <= push_data;
    end

    // Show-ahead output
    assign head = mem[rd_ptr];

endmodule

// File: frame_store.sv
`timescale 1ns/10ps

module frame_store (
    input  logic   clk,
    input  logic   rst_n,
    store_if.store bus
);
    import pix_pkg::*;

    logic [WORD_BITS-1:0]  mem [BLOCK_COUNT][FRAME_WORDS];
    logic [BLOCK_BITS-1:0] blk;
    logic [ADDR_BITS-1:0]  word_idx;
    logic                  wr_mode;
    logic                  fetch;
    logic                  accept;
    logic                  xfer;
    logic                  last;

    assign accept = bus.cmd_ready && bus.cmd_trigger;
    // data_ready is only ever high inside a command
    assign xfer   = bus.data_ready && bus.data_trigger;
    assign last   = (word_idx == ADDR_BITS'(FRAME_WORDS - 1));

    // ====================
    // Command sequencing
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus.cmd_ready  <= 1'b1;
            bus.data_ready <= 1'b0;
            blk            <= '0;
            word_idx       <= '0;
            wr_mode        <= 1'b0;
            fetch          <= 1'b0;
        end else if (accept) begin
            bus.cmd_ready  <= 1'b0;
            blk            <= bus.cmd_block;
            word_idx       <= '0;
            wr_mode        <= bus.cmd_write;
            // Writes are open at once, reads start with a fetch
            bus.data_ready <= bus.cmd_write;
            fetch          <= !bus.cmd_write;
        end else if (fetch) begin
            fetch          <= 1'b0;
            bus.data_ready <= 1'b1;
        end else if (xfer) begin
            if (last) begin
                bus.cmd_ready  <= 1'b1;
                bus.data_ready <= 1'b0;
            end else begin
                word_idx <= word_idx + 1'b1;
                if (!wr_mode) begin
                    bus.data_ready <= 1'b0;
                    fetch          <= 1'b1;
                end
            end
        end
    end

    // ====================
    // Word memory
    // ====================
    always_ff @(posedge clk) begin
        if (xfer && wr_mode) begin
            mem[blk][word_idx] <= bus.data_write;
        end
        // Registered read, word index already advanced
        if (fetch) begin
            bus.data_read <= mem[blk][word_idx];
        end
    end

endmodule

// File: pix_controller.sv
`timescale 1ns/10ps

module pix_controller (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           cmd_start,
    input  logic                           cmd_op,
    input  logic [pix_pkg::BLOCK_BITS-1:0] cmd_block,
    output logic                           cmd_done,
    output logic                           busy,
    output logic                           arm,
    output logic                           fifo_flush,
    input  logic                           fifo_not_empty,
    output logic                           fifo_pop,
    input  logic [pix_pkg::WORD_BITS-1:0]  fifo_data,
    output logic                           readout_ready,
    input  logic                           readout_trigger,
    output logic [pix_pkg::WORD_BITS-1:0]  readout_data,
    store_if.ctrl                          store
);
    import pix_pkg::*;

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_ISSUE  = 2'd1;
    localparam logic [1:0] ST_COPY   = 2'd2;
    localparam logic [1:0] ST_STREAM = 2'd3;

    logic [1:0] state;
    logic       op_q;
    logic       start_ok;

    // Starts while busy are dropped
    assign start_ok = (state == ST_IDLE) && cmd_start;

    // ====================
    // Command FSM
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state             <= ST_IDLE;
            cmd_done          <= 1'b0;
            arm               <= 1'b0;
            fifo_flush        <= 1'b0;
            store.cmd_trigger <= 1'b0;
        end else begin
            cmd_done   <= 1'b0;
            arm        <= 1'b0;
            fifo_flush <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start_ok) begin
                        store.cmd_trigger <= 1'b1;
                        // Capture clears stale pixels and arms the gate
                        arm               <= (cmd_op == CMD_CAPTURE);
                        fifo_flush        <= (cmd_op == CMD_CAPTURE);
                        state             <= ST_ISSUE;
                    end
                end

                // Hold the command until the store takes it
                ST_ISSUE: begin
                    if (store.cmd_ready && store.cmd_trigger) begin
                        store.cmd_trigger <= 1'b0;
                        state <= (op_q == CMD_READOUT) ? ST_STREAM : ST_COPY;
                    end
                end

                // Store raises cmd_ready once the whole block is moved
                ST_COPY, ST_STREAM: begin
                    if (store.cmd_ready) begin
                        cmd_done <= 1'b1;
                        state    <= ST_IDLE;
                    end
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

    // Latched command fields
    always_ff @(posedge clk) begin
        if (start_ok) begin
            op_q            <= cmd_op;
            store.cmd_block <= cmd_block;
            store.cmd_write <= (cmd_op == CMD_CAPTURE);
        end
    end

    assign busy = (state != ST_IDLE);

    // ====================
    // Data routing
    // ====================
    // FIFO to store, one word per cycle
    assign fifo_pop         = (state == ST_COPY) && fifo_not_empty && store.data_ready;
    assign store.data_write = fifo_data;

    assign store.data_trigger = (state == ST_COPY)   ? fifo_not_empty :
                                (state == ST_STREAM) ? readout_trigger : 1'b0;

    // Readout mirrors the store's read handshake
    assign readout_ready = (state == ST_STREAM) && store.data_ready;
    assign readout_data  = store.data_read;

endmodule

// File: pix_top.sv
`timescale 1ns/10ps

module pix_top (
    input  logic                           clk,
    input  logic                           rst_n,
    // Command port
    input  logic                           cmd_start,
    input  logic                           cmd_op,
    input  logic [pix_pkg::BLOCK_BITS-1:0] cmd_block,
    output logic                           cmd_done,
    output logic                           busy,
    // Pixel port
    input  logic                           pix_valid,
    input  logic [pix_pkg::PIX_BITS-1:0]   pix_d,
    input  logic                           pix_fv,
    input  logic                           pix_lv,
    // Readout port
    output logic                           readout_ready,
    input  logic                           readout_trigger,
    output logic [pix_pkg::WORD_BITS-1:0]  readout_data
);
    import pix_pkg::*;

    logic                 arm;
    logic                 push;
    logic [WORD_BITS-1:0] push_data;
    logic                 fifo_flush;
    logic                 fifo_not_empty;
    logic                 fifo_pop;
    logic [WORD_BITS-1:0] fifo_head;

    store_if bus ();

    pix_controller u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .cmd_start       (cmd_start),
        .cmd_op          (cmd_op),
        .cmd_block       (cmd_block),
        .cmd_done        (cmd_done),
        .busy            (busy),
        .arm             (arm),
        .fifo_flush      (fifo_flush),
        .fifo_not_empty  (fifo_not_empty),
        .fifo_pop        (fifo_pop),
        .fifo_data       (fifo_head),
        .readout_ready   (readout_ready),
        .readout_trigger (readout_trigger),
        .readout_data    (readout_data),
        .store           (bus.ctrl)
    );

    frame_gate u_gate (
        .clk       (clk),
        .rst_n     (rst_n),
        .arm       (arm),
        .pix_valid (pix_valid),
        .pix_d     (pix_d),
        .pix_fv    (pix_fv),
        .pix_lv    (pix_lv),
        .push      (push),
        .push_data (push_data)
    );

    pix_fifo u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (fifo_flush),
        .push      (push),
        .push_data (push_data),
        .not_empty (fifo_not_empty),
        .pop       (fifo_pop),
        .head      (fifo_head)
    );

    frame_store u_store (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (bus.store)
    );

endmodule

// File: tb_pix_top.sv
`timescale 1ns/10ps

module tb_pix_top;
    import pix_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int FRAME_GAP    = 10;
    localparam int LINE_GAP     = 2;
    localparam int LINES        = 4;
    localparam int LINE_PIX     = 6;
    localparam int FRAME_CYCLES = FRAME_GAP + LINES * (LINE_GAP + LINE_PIX) + LINE_GAP;
    localparam int MAX_FRAMES   = 64;
    localparam int NUM_ROWS     = 8;
    localparam int WATCHDOG_NS  = (NUM_ROWS * FRAME_CYCLES * 3 + RESET_CYCLES) * CLK_PERIOD;

    typedef struct packed {
        logic                  op;
        logic [BLOCK_BITS-1:0] blk;
        logic                  mid;
        logic                  gaps;
        logic                  extra;
        logic [BLOCK_BITS-1:0] victim;
    } row_t;

    // ====================
    // Test table
    // ====================
    // op, block, start mid-frame, trigger gaps, start while busy, its block
    localparam row_t ROWS [NUM_ROWS] = '{
        '{CMD_CAPTURE, 3'd2, 1'b0, 1'b0, 1'b0, 3'd0},
        '{CMD_READOUT, 3'd2, 1'b0, 1'b0, 1'b0, 3'd0},
        '{CMD_CAPTURE, 3'd3, 1'b1, 1'b0, 1'b1, 3'd2},
        '{CMD_READOUT, 3'd3, 1'b0, 1'b1, 1'b0, 3'd0},
        '{CMD_CAPTURE, 3'd5, 1'b0, 1'b0, 1'b0, 3'd0},
        '{CMD_READOUT, 3'd2, 1'b0, 1'b1, 1'b1, 3'd3},
        '{CMD_READOUT, 3'd5, 1'b0, 1'b1, 1'b0, 3'd0},
        '{CMD_READOUT, 3'd3, 1'b0, 1'b0, 1'b0, 3'd0}
    };

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  cmd_start;
    logic                  cmd_op;
    logic [BLOCK_BITS-1:0] cmd_block;
    logic                  cmd_done;
    logic                  busy;
    logic                  pix_valid;
    logic [PIX_BITS-1:0]   pix_d;
    logic                  pix_fv;
    logic                  pix_lv;
    logic                  readout_ready;
    logic                  readout_trigger;
    logic [WORD_BITS-1:0]  readout_data;

    // Pixels of each frame sent, and which frame each block holds
    logic [PIX_BITS-1:0] frame_pix [MAX_FRAMES][FRAME_WORDS];
    int                  block_frame [BLOCK_COUNT];
    int                  frame_count;
    int                  done_count;
    logic [31:0]         pix_lfsr = 32'h47b3;
    logic [31:0]         gap_lfsr = 32'h47b3;

    pix_top dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .cmd_start       (cmd_start),
        .cmd_op          (cmd_op),
        .cmd_block       (cmd_block),
        .cmd_done        (cmd_done),
        .busy            (busy),
        .pix_valid       (pix_valid),
        .pix_d           (pix_d),
        .pix_fv          (pix_fv),
        .pix_lv          (pix_lv),
        .readout_ready   (readout_ready),
        .readout_trigger (readout_trigger),
        .readout_data    (readout_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    // ====================
    // Pixel source
    // ====================
    task automatic run_pixel_model();
        logic [PIX_BITS-1:0] value;
        value       = '0;
        frame_count = 0;
        pix_valid <= 1'b0;
        pix_d     <= '0;
        pix_fv    <= 1'b0;
        pix_lv    <= 1'b0;
        wait (rst_n === 1'b1);
        forever begin
            repeat (FRAME_GAP) @(negedge clk);
            pix_fv <= 1'b1;
            frame_count = frame_count + 1;
            for (int ln = 0; ln < LINES; ln++) begin
                repeat (LINE_GAP) @(negedge clk);
                for (int px = 0; px < LINE_PIX; px++) begin
                    // One LFSR step per pixel bit
                    for (int b = 0; b < PIX_BITS; b++) begin
                        pix_lfsr = lfsr_step(pix_lfsr);
                        value    = {value[PIX_BITS-2:0], pix_lfsr[0]};
                    end
                    if (frame_count <= MAX_FRAMES)
                        frame_pix[frame_count - 1][ln * LINE_PIX + px] = value;
                    pix_lv    <= 1'b1;
                    pix_valid <= 1'b1;
                    pix_d     <= value;
                    @(negedge clk);
                end
                pix_lv    <= 1'b0;
                pix_valid <= 1'b0;
                pix_d     <= '0;
            end
            repeat (LINE_GAP) @(negedge clk);
            pix_fv <= 1'b0;
        end
    endtask

    initial run_pixel_model();

    always @(negedge clk) begin
        if (!rst_n)
            done_count <= 0;
        else if (cmd_done)
            done_count <= done_count + 1;
    end

    // Take a whole block, only triggering while ready is high
    task automatic read_block(input logic [BLOCK_BITS-1:0] blk, input logic gaps);
        int                   idx;
        logic                 take;
        logic [WORD_BITS-1:0] exp_word;
        idx = 0;
        while (idx < FRAME_WORDS) begin
            @(negedge clk);
            take = 1'b0;
            if (readout_ready) begin
                take = 1'b1;
                if (gaps) begin
                    gap_lfsr = lfsr_step(gap_lfsr);
                    take     = gap_lfsr[0];
                end
            end
            if (take) begin
                exp_word = WORD_BITS'(frame_pix[block_frame[blk]][idx]);
                check_value(32'(readout_data), 32'(exp_word),
                            $sformatf("block %0d word %0d", blk, idx));
                idx++;
            end
            readout_trigger <= take;
        end
        @(negedge clk);
        readout_trigger <= 1'b0;
    endtask

    task automatic wait_done();
        while (cmd_done !== 1'b1) @(negedge clk);
        check_value(32'(busy), 32'd0, "busy with cmd_done");
        @(negedge clk);
        check_value(32'(cmd_done), 32'd0, "cmd_done wider than one cycle");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: a command did not finish within %0d ns", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $fatal(1);
    end

    // ====================
    // Main sequence
    // ====================
    initial begin
        row_t row;
        int   exp_frame;
        exp_frame       = 0;
        rst_n           = 1'b0;
        cmd_start       = 1'b0;
        cmd_op          = CMD_CAPTURE;
        cmd_block       = '0;
        readout_trigger = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value(32'(busy), 32'd0, "busy after reset");
        check_value(32'(cmd_done), 32'd0, "cmd_done after reset");
        check_value(32'(readout_ready), 32'd0, "readout_ready after reset");

        for (int r = 0; r < NUM_ROWS; r++) begin
            row = ROWS[r];
            // Line up the start with the frame timing
            if (row.op == CMD_CAPTURE) begin
                if (row.mid) begin
                    @(posedge pix_fv);
                    repeat (8) @(negedge clk);
                end else begin
                    @(negedge pix_fv);
                    repeat (2) @(negedge clk);
                end
                // Next frame to begin is the one captured
                exp_frame = frame_count;
            end
            cmd_start <= 1'b1;
            cmd_op    <= row.op;
            cmd_block <= row.blk;
            @(negedge clk);
            cmd_start <= 1'b0;
            check_value(32'(busy), 32'd1, $sformatf("busy after start of row %0d", r));
            if (row.extra) begin
                cmd_start <= 1'b1;
                cmd_op    <= CMD_CAPTURE;
                cmd_block <= row.victim;
                @(negedge clk);
                cmd_start <= 1'b0;
            end
            if (row.op == CMD_READOUT)
                read_block(row.blk, row.gaps);
            wait_done();
            if (row.op == CMD_CAPTURE)
                block_frame[row.blk] = exp_frame;
        end

        repeat (4) @(negedge clk);
        check_value(32'(done_count), 32'(NUM_ROWS), "cmd_done pulse count");
        check_value(32'(busy), 32'd0, "busy at end");
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: list.f
pix_pkg.sv
store_if.sv
frame_gate.sv
pix_fifo.sv
frame_store.sv
pix_controller.sv
pix_top.sv
tb_pix_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_pix_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/10ps -j 0

SOURCES := $(shell cat $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJ_DIR)
